// ==== rtl/csr_pkg.sv ====
// Machine mode only with four HPM counters, 24 events and a hart ID fixed at 0
package csr_pkg;

   // -------------------------------------------------------------------------
   // Widths and sizes
   // -------------------------------------------------------------------------
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;
   localparam int NUM_MHPM   = 4;
   localparam int EV_SEL_SZ  = 5;
   localparam int NUM_EVENTS = 24;
   localparam int NUM_RET    = 13;
   localparam int CAUSE_W    = 4;
   // mcycle and minstret come first, then the HPM counters
   localparam int NUM_CNT    = NUM_MHPM + 2;

   // Retire classes, one strobe each
   localparam int LD_RET   = 0;
   localparam int ST_RET   = 1;
   localparam int CSR_RET  = 2;
   localparam int SYS_RET  = 3;
   localparam int ALU_RET  = 4;
   localparam int BXX_RET  = 5;
   localparam int JAL_RET  = 6;
   localparam int JALR_RET = 7;
   localparam int IM_RET   = 8;
   localparam int ID_RET   = 9;
   localparam int IR_RET   = 10;
   localparam int HINT_RET = 11;
   localparam int UNK_RET  = 12;

   // Exception causes counted by the event logic
   localparam int CAUSE_IADDR_MISAL = 0;
   localparam int CAUSE_IACC_FAULT  = 1;
   localparam int CAUSE_ILLEGAL     = 2;
   localparam int CAUSE_BREAK       = 3;
   localparam int CAUSE_LADDR_MISAL = 4;
   localparam int CAUSE_SADDR_MISAL = 6;
   localparam int CAUSE_ECALL_U     = 8;

   // Bit positions
   localparam int MSTAT_MIE_BIT = 3;
   localparam int MEI_BIT       = 11;
   // Top two address bits of 3 mark the read-only space
   localparam logic [1:0] ACC_RO = 2'b11;

   // -------------------------------------------------------------------------
   // Addresses
   // -------------------------------------------------------------------------
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS       = 12'h300;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIE           = 12'h304;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC         = 12'h305;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTINHIBIT = 12'h320;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMEVENT3    = 12'h323;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH      = 12'h340;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC          = 12'h341;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE        = 12'h342;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL         = 12'h343;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIP           = 12'h344;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE        = 12'hB00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET      = 12'hB02;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMCOUNTER3  = 12'hB03;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH       = 12'hB80;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH     = 12'hB82;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMCOUNTER3H = 12'hB83;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID     = 12'hF11;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID       = 12'hF12;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID        = 12'hF13;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID       = 12'hF14;

   // -------------------------------------------------------------------------
   // Reset values and read-only masks
   // -------------------------------------------------------------------------
   // mpp = machine mode
   localparam logic [XLEN-1:0] MSTAT_INIT  = 32'h0000_1800;
   // Direct mode, bit 1 stays clear
   localparam logic [XLEN-1:0] MTVEC_INIT  = 32'h0000_0100;
   localparam logic [XLEN-1:0] MVENDOR_ID  = 32'h0000_0000;
   localparam logic [XLEN-1:0] MARCH_ID    = 32'h0000_0023;
   localparam logic [XLEN-1:0] MIMP_ID     = 32'h0000_0001;
   localparam logic [XLEN-1:0] MHART_ID    = 32'h0000_0000;

   // Only mie, mpie and mpp are writable
   localparam logic [XLEN-1:0] MSTAT_RO    = ~32'h0000_1888;
   // Only msie, mtie and meie are writable
   localparam logic [XLEN-1:0] MIE_RO      = ~32'h0000_0888;
   localparam logic [XLEN-1:0] MIP_RO      = 32'hFFFF_FFFF;
   localparam logic [XLEN-1:0] MTVEC_RO    = 32'h0000_0002;
   localparam logic [XLEN-1:0] MEPC_RO     = 32'h0000_0001;
   localparam logic [XLEN-1:0] MINHIBIT_RO = 32'h0000_0002;

   // -------------------------------------------------------------------------
   // Types
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [1:0] access;
      logic [1:0] priv;
      logic [7:0] index;
   } csr_addr_s;

   // Same 12 bits, as a number or as fields
   typedef union packed {
      logic [CSR_ADDR_W-1:0] raw;
      csr_addr_s             f;
   } csr_addr_u;

   typedef enum logic [4:0] {
      SEL_NONE, SEL_MSTATUS, SEL_MIE, SEL_MTVEC,
      SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
      SEL_MCOUNTINHIBIT,
      SEL_MHPMEVENT3, SEL_MHPMEVENT4, SEL_MHPMEVENT5, SEL_MHPMEVENT6,
      SEL_MCYCLE, SEL_MINSTRET,
      SEL_MHPMCOUNTER3, SEL_MHPMCOUNTER4, SEL_MHPMCOUNTER5, SEL_MHPMCOUNTER6,
      SEL_MCYCLEH, SEL_MINSTRETH,
      SEL_MHPMCOUNTER3H, SEL_MHPMCOUNTER4H, SEL_MHPMCOUNTER5H, SEL_MHPMCOUNTER6H,
      SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
   } csr_sel_e;

endpackage

// ==== rtl/csr_decode.sv ====
// Combinational decode; unimplemented addresses and writes to read-only space read 0
`timescale 1ns/1ps

module csr_decode
(
   input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic                           csr_we,
   input  logic [csr_pkg::XLEN-1:0]       csr_wdata,
   input  logic [csr_pkg::XLEN-1:0]       trap_rdata,
   input  logic [csr_pkg::XLEN-1:0]       cnt_rdata,
   output csr_pkg::csr_sel_e              sel,
   output logic                           wr_en,
   output logic [csr_pkg::XLEN-1:0]       csr_rdata,
   output logic                           csr_illegal
);
   import csr_pkg::*;

   csr_addr_u       addr_u;
   logic            ro_write;
   logic [XLEN-1:0] info_rdata;

   assign addr_u.raw = csr_addr;

   // -------------------------------------------------------------------------
   // Address to register select
   // -------------------------------------------------------------------------
   always_comb
   begin
      sel = SEL_NONE;
      case (addr_u.raw)
         ADDR_MSTATUS:       sel = SEL_MSTATUS;
         ADDR_MIE:           sel = SEL_MIE;
         ADDR_MTVEC:         sel = SEL_MTVEC;
         ADDR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
         ADDR_MSCRATCH:      sel = SEL_MSCRATCH;
         ADDR_MEPC:          sel = SEL_MEPC;
         ADDR_MCAUSE:        sel = SEL_MCAUSE;
         ADDR_MTVAL:         sel = SEL_MTVAL;
         ADDR_MIP:           sel = SEL_MIP;
         ADDR_MCYCLE:        sel = SEL_MCYCLE;
         ADDR_MINSTRET:      sel = SEL_MINSTRET;
         ADDR_MCYCLEH:       sel = SEL_MCYCLEH;
         ADDR_MINSTRETH:     sel = SEL_MINSTRETH;
         ADDR_MVENDORID:     sel = SEL_MVENDORID;
         ADDR_MARCHID:       sel = SEL_MARCHID;
         ADDR_MIMPID:        sel = SEL_MIMPID;
         ADDR_MHARTID:       sel = SEL_MHARTID;
         default:            sel = SEL_NONE;
      endcase
      // HPM selectors and counters sit at consecutive addresses
      for (int n = 0; n < NUM_MHPM; n++)
      begin
         if (addr_u.raw == ADDR_MHPMEVENT3 + CSR_ADDR_W'(n))
            sel = csr_sel_e'(SEL_MHPMEVENT3 + n);
         if (addr_u.raw == ADDR_MHPMCOUNTER3 + CSR_ADDR_W'(n))
            sel = csr_sel_e'(SEL_MHPMCOUNTER3 + n);
         if (addr_u.raw == ADDR_MHPMCOUNTER3H + CSR_ADDR_W'(n))
            sel = csr_sel_e'(SEL_MHPMCOUNTER3H + n);
      end
   end

   // Access field flags the read-only space
   assign ro_write    = csr_we && (addr_u.f.access == ACC_RO);
   assign csr_illegal = (sel == SEL_NONE) || ro_write;
   assign wr_en       = csr_we && !csr_illegal;

   // -------------------------------------------------------------------------
   // Read data
   // -------------------------------------------------------------------------
   // Information registers are plain constants
   always_comb
   begin
      case (sel)
         SEL_MVENDORID: info_rdata = MVENDOR_ID;
         SEL_MARCHID:   info_rdata = MARCH_ID;
         SEL_MIMPID:    info_rdata = MIMP_ID;
         SEL_MHARTID:   info_rdata = MHART_ID;
         default:       info_rdata = '0;
      endcase
   end

   // Blocks return 0 for registers they do not own
   assign csr_rdata = csr_illegal ? '0 : (info_rdata | trap_rdata | cnt_rdata);

   // A write carries known data into the blocks
   a_wdata_known: assert final (!wr_en || !$isunknown(csr_wdata));

   // Only the information registers live in the read-only space
   a_ro_space: assert final ((sel == SEL_NONE) ||
                             ((addr_u.f.access == ACC_RO) ==
                              (sel inside {SEL_MVENDORID, SEL_MARCHID,
                                           SEL_MIMPID, SEL_MHARTID})));

endmodule

// ==== rtl/csr_trap_regs.sv ====
// Machine trap registers only; mip bits other than meip read 0 and meip lags ext_irq by one clock
`timescale 1ns/1ps

module csr_trap_regs
(
   input  logic                     clk_in,
   input  logic                     rst_n,
   input  csr_pkg::csr_sel_e        sel,
   input  logic                     wr_en,
   input  logic [csr_pkg::XLEN-1:0] wdata,
   input  logic                     ext_irq,
   output logic [csr_pkg::XLEN-1:0] trap_rdata,
   output logic                     irq_pending
);
   import csr_pkg::*;

   logic [XLEN-1:0] mstatus;
   logic [XLEN-1:0] mie;
   logic [XLEN-1:0] mtvec;
   logic [XLEN-1:0] mscratch;
   logic [XLEN-1:0] mepc;
   logic [XLEN-1:0] mcause;
   logic [XLEN-1:0] mtval;
   logic            mip_meip;
   logic [XLEN-1:0] mip_rd;

   // Writable bits come from the bus and read-only bits keep the reset value
   function automatic logic [XLEN-1:0] ro_merge(input logic [XLEN-1:0] wd,
                                                input logic [XLEN-1:0] ro,
                                                input logic [XLEN-1:0] init);
      return (wd & ~ro) | (init & ro);
   endfunction

   // -------------------------------------------------------------------------
   // Register writes
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         mstatus  <= MSTAT_INIT;
         mie      <= '0;
         mtvec    <= MTVEC_INIT;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
      end
      else if (wr_en)
      begin
         case (sel)
            SEL_MSTATUS:  mstatus  <= ro_merge(wdata, MSTAT_RO, MSTAT_INIT);
            SEL_MIE:      mie      <= ro_merge(wdata, MIE_RO, '0);
            SEL_MTVEC:    mtvec    <= ro_merge(wdata, MTVEC_RO, MTVEC_INIT);
            SEL_MSCRATCH: mscratch <= wdata;
            SEL_MEPC:     mepc     <= ro_merge(wdata, MEPC_RO, '0);
            SEL_MCAUSE:   mcause   <= wdata;
            SEL_MTVAL:    mtval    <= wdata;
            default:      ;
         endcase
      end
   end

   // External interrupt line through one register stage
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
         mip_meip <= 1'b0;
      else
         mip_meip <= ext_irq;
   end

   // Only meip is live and the other mip bits read 0
   always_comb
   begin
      mip_rd          = '0;
      mip_rd[MEI_BIT] = mip_meip;
   end

   // -------------------------------------------------------------------------
   // Read mux and interrupt
   // -------------------------------------------------------------------------
   always_comb
   begin
      case (sel)
         SEL_MSTATUS:  trap_rdata = mstatus;
         SEL_MIE:      trap_rdata = mie;
         SEL_MTVEC:    trap_rdata = mtvec;
         SEL_MSCRATCH: trap_rdata = mscratch;
         SEL_MEPC:     trap_rdata = mepc;
         SEL_MCAUSE:   trap_rdata = mcause;
         SEL_MTVAL:    trap_rdata = mtval;
         SEL_MIP:      trap_rdata = mip_rd;
         default:      trap_rdata = '0;
      endcase
   end

   // Pending, enabled, and globally enabled
   assign irq_pending = mip_meip & mie[MEI_BIT] & mstatus[MSTAT_MIE_BIT];

   // Alignment bits stay clear across any sequence of writes
   a_mepc_align: assert property (@(posedge clk_in) disable iff (!rst_n) !mepc[0]);
   a_mtvec_mode: assert property (@(posedge clk_in) disable iff (!rst_n) !mtvec[1]);

endmodule

// ==== rtl/csr_hpm_events.sv ====
// Assumes at most one instruction retires per clock, so retire counts are single bits
`timescale 1ns/1ps

module csr_hpm_events
(
   input  logic [csr_pkg::NUM_RET-1:0]    ret_cnt,
   input  logic                           e_flag,
   input  logic [csr_pkg::CAUSE_W-1:0]    e_cause,
   input  logic                           ext_irq,
   output logic                           total_retired,
   output logic [csr_pkg::NUM_EVENTS-1:0] events
);
   import csr_pkg::*;

   // One-hot exception cause, empty without e_flag
   logic [(1<<CAUSE_W)-1:0] exc_hit;
   logic                    branch_ret;
   logic                    misaligned;

   assign exc_hit       = {{((1<<CAUSE_W)-1){1'b0}}, e_flag} << e_cause;
   assign total_retired = |ret_cnt;
   assign branch_ret    = ret_cnt[BXX_RET] | ret_cnt[JAL_RET] | ret_cnt[JALR_RET];
   assign misaligned    = exc_hit[CAUSE_IADDR_MISAL] | exc_hit[CAUSE_LADDR_MISAL]
                        | exc_hit[CAUSE_SADDR_MISAL];

   // -------------------------------------------------------------------------
   // Event map
   // -------------------------------------------------------------------------
   // Null event, selector 0 never counts
   assign events[0]         = 1'b0;
   // One event per retire class
   assign events[NUM_RET:1] = ret_cnt;
   assign events[14]        = exc_hit[CAUSE_IADDR_MISAL];
   assign events[15]        = exc_hit[CAUSE_IACC_FAULT];
   assign events[16]        = exc_hit[CAUSE_ILLEGAL];
   // Any control transfer
   assign events[17]        = branch_ret;
   assign events[18]        = misaligned;
   assign events[19]        = total_retired;
   assign events[20]        = exc_hit[CAUSE_BREAK];
   assign events[21]        = exc_hit[CAUSE_SADDR_MISAL];
   assign events[22]        = exc_hit[CAUSE_ECALL_U];
   assign events[23]        = ext_irq;

   // The pipeline retires one instruction at most
   a_one_ret: assert final ($onehot0(ret_cnt));

endmodule

// ==== rtl/csr_counters.sv ====
// 64-bit counters wrap silently; a half write wins over the increment in the same clock
`timescale 1ns/1ps

module csr_counters
(
   input  logic                           clk_in,
   input  logic                           rst_n,
   input  csr_pkg::csr_sel_e              sel,
   input  logic                           wr_en,
   input  logic [csr_pkg::XLEN-1:0]       wdata,
   input  logic                           total_retired,
   input  logic [csr_pkg::NUM_EVENTS-1:0] events,
   output logic [csr_pkg::XLEN-1:0]       cnt_rdata
);
   import csr_pkg::*;

   logic [XLEN-1:0]      inhibit;
   logic [EV_SEL_SZ-1:0] ev_sel [NUM_MHPM];
   logic [63:0]          cnt [NUM_CNT];
   logic [NUM_CNT-1:0]   cnt_evt;
   logic [NUM_CNT-1:0]   cnt_inc;
   logic [NUM_CNT-1:0]   wr_lo;
   logic [NUM_CNT-1:0]   wr_hi;

   // Counter i: 0 mcycle, 1 minstret, 2.. mhpmcounter3..
   function automatic csr_sel_e lo_sel(input int i);
      return (i == 0) ? SEL_MCYCLE :
             (i == 1) ? SEL_MINSTRET : csr_sel_e'(SEL_MHPMCOUNTER3 + i - 2);
   endfunction

   function automatic csr_sel_e hi_sel(input int i);
      return (i == 0) ? SEL_MCYCLEH :
             (i == 1) ? SEL_MINSTRETH : csr_sel_e'(SEL_MHPMCOUNTER3H + i - 2);
   endfunction

   // Inhibit bit 1 is the unused time slot
   function automatic int inh_bit(input int i);
      return (i == 0) ? 0 : (i == 1) ? 2 : i + 1;
   endfunction

   // -------------------------------------------------------------------------
   // Increment and write enables
   // -------------------------------------------------------------------------
   always_comb
   begin
      cnt_evt[0] = 1'b1;
      cnt_evt[1] = total_retired;
      for (int n = 0; n < NUM_MHPM; n++)
         cnt_evt[n+2] = events[ev_sel[n]];
      for (int i = 0; i < NUM_CNT; i++)
      begin
         cnt_inc[i] = cnt_evt[i] & ~inhibit[inh_bit(i)];
         wr_lo[i]   = wr_en && (sel == lo_sel(i));
         wr_hi[i]   = wr_en && (sel == hi_sel(i));
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_CNT; i++)
            cnt[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_CNT; i++)
         begin
            if (wr_lo[i])
               cnt[i][31:0] <= wdata;
            else if (wr_hi[i])
               cnt[i][63:32] <= wdata;
            else if (cnt_inc[i])
               cnt[i] <= cnt[i] + 64'd1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Inhibit and event selectors
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         inhibit <= '0;
         for (int n = 0; n < NUM_MHPM; n++)
            ev_sel[n] <= '0;
      end
      else if (wr_en)
      begin
         if (sel == SEL_MCOUNTINHIBIT)
            inhibit <= wdata & ~MINHIBIT_RO;
         // Out of range selections fall back to the null event
         for (int n = 0; n < NUM_MHPM; n++)
            if (sel == SEL_MHPMEVENT3 + n)
               ev_sel[n] <= (wdata < NUM_EVENTS) ? wdata[EV_SEL_SZ-1:0] : '0;
      end
   end

   always_comb
   begin
      cnt_rdata = '0;
      if (sel == SEL_MCOUNTINHIBIT)
         cnt_rdata = inhibit;
      for (int n = 0; n < NUM_MHPM; n++)
         if (sel == SEL_MHPMEVENT3 + n)
            cnt_rdata = XLEN'(ev_sel[n]);
      for (int i = 0; i < NUM_CNT; i++)
      begin
         if (sel == lo_sel(i))
            cnt_rdata = cnt[i][31:0];
         if (sel == hi_sel(i))
            cnt_rdata = cnt[i][63:32];
      end
   end

   // Selectors always index inside the event vector
   for (genvar n = 0; n < NUM_MHPM; n++)
   begin : g_sel_chk
      a_sel_range: assert property (@(posedge clk_in) disable iff (!rst_n)
                                    ev_sel[n] < NUM_EVENTS);
   end

endmodule

// ==== rtl/csr_regs.sv ====
// Single CSR port without handshake; reads are combinational and writes land on the next clock
`timescale 1ns/1ps

module csr_regs
(
   input  logic                           clk_in,
   input  logic                           rst_n,
   input  logic                           ext_irq,
   input  logic [csr_pkg::NUM_RET-1:0]    ret_cnt,
   input  logic                           e_flag,
   input  logic [csr_pkg::CAUSE_W-1:0]    e_cause,
   input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
   input  logic                           csr_we,
   input  logic [csr_pkg::XLEN-1:0]       csr_wdata,
   output logic [csr_pkg::XLEN-1:0]       csr_rdata,
   output logic                           csr_illegal,
   output logic                           total_retired,
   output logic                           irq_pending
);
   import csr_pkg::*;

   csr_sel_e              sel;
   logic                  wr_en;
   logic [XLEN-1:0]       trap_rdata;
   logic [XLEN-1:0]       cnt_rdata;
   logic [NUM_EVENTS-1:0] events;

   // -------------------------------------------------------------------------
   // Decode and read mux
   // -------------------------------------------------------------------------
   csr_decode u_decode (
      .csr_addr    (csr_addr),
      .csr_we      (csr_we),
      .csr_wdata   (csr_wdata),
      .trap_rdata  (trap_rdata),
      .cnt_rdata   (cnt_rdata),
      .sel         (sel),
      .wr_en       (wr_en),
      .csr_rdata   (csr_rdata),
      .csr_illegal (csr_illegal)
   );

   // Trap registers and interrupt
   csr_trap_regs u_trap_regs (
      .clk_in      (clk_in),
      .rst_n       (rst_n),
      .sel         (sel),
      .wr_en       (wr_en),
      .wdata       (csr_wdata),
      .ext_irq     (ext_irq),
      .trap_rdata  (trap_rdata),
      .irq_pending (irq_pending)
   );

   // -------------------------------------------------------------------------
   // Counters and their event sources
   // -------------------------------------------------------------------------
   csr_hpm_events u_hpm_events (
      .ret_cnt       (ret_cnt),
      .e_flag        (e_flag),
      .e_cause       (e_cause),
      .ext_irq       (ext_irq),
      .total_retired (total_retired),
      .events        (events)
   );

   csr_counters u_counters (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .sel           (sel),
      .wr_en         (wr_en),
      .wdata         (csr_wdata),
      .total_retired (total_retired),
      .events        (events),
      .cnt_rdata     (cnt_rdata)
   );

endmodule

// ==== verif/csr_regs_tb.sv ====
// Run from the project root so verif/csr_patterns.txt opens; outputs sampled 5 ns after negedge
`timescale 1ns/1ps

module csr_regs_tb;
   import csr_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int SAMPLE_DLY = CLK_PERIOD / 4;
   localparam int MAX_LINES  = 500;

   logic                  clk_in;
   logic                  rst_n;
   logic                  ext_irq;
   logic [NUM_RET-1:0]    ret_cnt;
   logic                  e_flag;
   logic [CAUSE_W-1:0]    e_cause;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic                  csr_we;
   logic [XLEN-1:0]       csr_wdata;
   logic [XLEN-1:0]       csr_rdata;
   logic                  csr_illegal;
   logic                  total_retired;
   logic                  irq_pending;

   int unsigned     mismatch_cnt;
   int unsigned     other_cnt;
   logic [31:0]     rng_state;
   logic [8*16-1:0] tname;

   csr_regs DUT (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .ext_irq       (ext_irq),
      .ret_cnt       (ret_cnt),
      .e_flag        (e_flag),
      .e_cause       (e_cause),
      .csr_addr      (csr_addr),
      .csr_we        (csr_we),
      .csr_wdata     (csr_wdata),
      .csr_rdata     (csr_rdata),
      .csr_illegal   (csr_illegal),
      .total_retired (total_retired),
      .irq_pending   (irq_pending)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD/2) clk_in = ~clk_in;
   end

   // -------------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------------
   // 32-bit xorshift that picks the retire classes
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_word(input logic [8*16-1:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("mismatch %0s %0s: expected %h, actual %h", name, what, exp, act);
         mismatch_cnt++;
      end
   endtask

   // No strobes, no write; address and ext_irq keep their value
   task automatic drive_idle();
      ret_cnt   = '0;
      e_flag    = 1'b0;
      e_cause   = '0;
      csr_we    = 1'b0;
      csr_wdata = '0;
   endtask

   task automatic idle_cycles(input int unsigned n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk_in);
         drive_idle();
      end
   endtask

   // Write strobe for one cycle with the illegal flag checked while it is up
   task automatic write_csr(input logic [8*16-1:0] name, input logic [11:0] addr,
                            input logic [31:0] data, input logic exp_ill);
      @(negedge clk_in);
      drive_idle();
      csr_addr  = addr;
      csr_we    = 1'b1;
      csr_wdata = data;
      #(SAMPLE_DLY);
      check_word(name, "illegal", {31'd0, exp_ill}, {31'd0, csr_illegal});
   endtask

   task automatic sample_csr(input logic [11:0] addr, output logic [31:0] val);
      @(negedge clk_in);
      drive_idle();
      csr_addr = addr;
      #(SAMPLE_DLY);
      val = csr_rdata;
   endtask

   task automatic read_csr(input logic [8*16-1:0] name, input logic [11:0] addr,
                           input logic [31:0] exp, input logic exp_ill);
      logic [31:0] val;
      sample_csr(addr, val);
      check_word(name, "rdata", exp, val);
      check_word(name, "illegal", {31'd0, exp_ill}, {31'd0, csr_illegal});
   endtask

   // Two mcycle samples k falling edges apart see k rising edges in between
   task automatic check_cycle_delta(input logic [8*16-1:0] name, input int unsigned k,
                                    input logic [31:0] exp_diff);
      logic [31:0] first;
      logic [31:0] second;
      sample_csr(ADDR_MCYCLE, first);
      idle_cycles(k - 1);
      sample_csr(ADDR_MCYCLE, second);
      check_word(name, "mcycle delta", exp_diff, second - first);
   endtask

   // Kind 0 pulses a retire class, kind 1 an exception cause
   task automatic pulse_events(input logic [8*16-1:0] name, input logic kind,
                               input logic [3:0] code, input int unsigned count);
      for (int i = 0; i < count; i++)
      begin
         @(negedge clk_in);
         drive_idle();
         if (kind == 1'b0)
            ret_cnt[code] = 1'b1;
         else
         begin
            e_flag  = 1'b1;
            e_cause = code;
         end
         #(SAMPLE_DLY);
         check_word(name, "total_retired", {31'd0, !kind}, {31'd0, total_retired});
      end
   endtask

   // Random retires; mhpmcounter3 counts control transfers, mhpmcounter4 ALU ops
   task automatic random_retire(input logic [8*16-1:0] name, input int unsigned n);
      int unsigned total;
      int unsigned branch;
      int unsigned alu;
      int          cls;
      total  = 0;
      branch = 0;
      alu    = 0;
      for (int i = 0; i < n; i++)
      begin
         rng_state = xorshift(rng_state);
         cls = int'(rng_state % NUM_RET);
         @(negedge clk_in);
         drive_idle();
         ret_cnt[cls] = 1'b1;
         #(SAMPLE_DLY);
         check_word(name, "total_retired", 32'd1, {31'd0, total_retired});
         total++;
         if (cls == BXX_RET || cls == JAL_RET || cls == JALR_RET)
            branch++;
         if (cls == ALU_RET)
            alu++;
      end
      read_csr(name, ADDR_MINSTRET, total, 1'b0);
      read_csr(name, ADDR_MHPMCOUNTER3, branch, 1'b0);
      read_csr(name, ADDR_MHPMCOUNTER3 + 12'd1, alu, 1'b0);
   endtask

   task automatic wait_irq(input logic [8*16-1:0] name, input logic exp,
                           input int unsigned max_cycles);
      logic done;
      done = 1'b0;
      for (int i = 0; i < max_cycles && !done; i++)
      begin
         @(negedge clk_in);
         drive_idle();
         #(SAMPLE_DLY);
         done = (irq_pending === exp);
      end
      assert (done)
      else
      begin
         $display("%0s: irq_pending did not reach %0b within %0d cycles",
                  name, exp, max_cycles);
         other_cnt++;
      end
   endtask

   task automatic run_op(input logic [7:0] op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c);
      case (op)
         "W": write_csr(tname, a[11:0], b, c[0]);
         "R": read_csr(tname, a[11:0], b, c[0]);
         "E": pulse_events(tname, a[0], b[3:0], c);
         "X": random_retire(tname, a);
         "D": check_cycle_delta(tname, a, b);
         "P": wait_irq(tname, a[0], b);
         "C": idle_cycles(a);
         "I":
         begin
            @(negedge clk_in);
            drive_idle();
            ext_irq = a[0];
         end
         default:
         begin
            $display("%0s: unknown operation '%c' in the pattern file", tname, op);
            other_cnt++;
         end
      endcase
   endtask

   // -------------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------------
   initial
   begin : main
      int              fd;
      int              n;
      int              lines;
      logic [8*96-1:0] line;
      logic [7:0]      first;
      logic [7:0]      op;
      logic [31:0]     a;
      logic [31:0]     b;
      logic [31:0]     c;

      rst_n        = 1'b0;
      ext_irq      = 1'b0;
      csr_addr     = '0;
      drive_idle();
      mismatch_cnt = 0;
      other_cnt    = 0;
      rng_state    = 32'hfbb5_8741;
      tname        = "reset";

      // Reset held for 5 rising edges, released on a falling edge
      for (int i = 0; i < 5; i++)
         @(posedge clk_in);
      @(negedge clk_in);
      rst_n = 1'b1;

      fd = $fopen("verif/csr_patterns.txt", "r");
      assert (fd != 0)
      else
      begin
         $display("could not open the pattern file verif/csr_patterns.txt");
         other_cnt++;
      end

      if (fd != 0)
      begin
         lines = 0;
         while (!$feof(fd) && lines < MAX_LINES)
         begin
            lines++;
            line = '0;
            n = $fgets(line, fd);
            // Skip blank lines and # comments
            if (n > 0 && $sscanf(line, " %c", first) == 1 && first != "#")
            begin
               n = $sscanf(line, "%s %c %h %h %h", tname, op, a, b, c);
               if (n == 5)
                  run_op(op, a, b, c);
               else
               begin
                  $display("pattern line %0d has %0d of 5 fields", lines, n);
                  other_cnt++;
               end
            end
         end
         $fclose(fd);
      end

      idle_cycles(1);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== verif/csr_patterns.txt ====
# name op a b c, a b c in hex; W addr data ill, R addr exp ill, E kind(0 ret,1 exc) code count
# X count, D idle exp_diff, P level max_cycles, I level, C cycles; unused fields are 0
rst_mstatus  R 300 00001800 0
rst_mtvec    R 305 00000100 0
rst_mie      R 304 00000000 0
rst_marchid  R F12 00000023 0
rst_mimpid   R F13 00000001 0
rst_minstret R B02 00000000 0
rst_hpm3     R B03 00000000 0
rst_mcycleh  R B80 00000000 0
rst_irq      P 0 1 0
mstat_ones   W 300 FFFFFFFF 0
mstat_ones   R 300 00001888 0
mtvec_ones   W 305 FFFFFFFF 0
mtvec_ones   R 305 FFFFFFFD 0
mepc_ones    W 341 FFFFFFFF 0
mepc_ones    R 341 FFFFFFFE 0
ill_read     R 7C0 00000000 1
ill_hartid   W F14 12345678 1
ill_hartid   R F14 00000000 0
cyc_run      D 7 7 0
inhibit_cyc  W 320 00000001 0
cyc_inh      D 5 0 0
sel_hpm3     W 323 00000011 0
sel_hpm4     W 324 00000005 0
sel_hpm5     W 325 00000010 0
clr_instret  W B02 00000000 0
rand_ret     X 20 0 0
exc_illegal  E 1 2 3
exc_hpm5     R B05 00000003 0
ret_load     E 0 0 4
ret_instret  R B02 00000024 0
irq_mie      W 304 00000800 0
irq_mstat    W 300 00000008 0
irq_on       I 1 0 0
irq_rise     P 1 1 0
irq_mip      R 344 00000800 0
irq_off      W 300 00000000 0
irq_drop     P 0 1 0
irq_clr      I 0 0 0
idle_end     C 3 0 0

// ==== build.f ====
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_hpm_events.sv
rtl/csr_counters.sv
rtl/csr_regs.sv
verif/csr_regs_tb.sv

// ==== Bender.yml ====
package:
  name: csr_regs

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_decode.sv
  - rtl/csr_trap_regs.sv
  - rtl/csr_hpm_events.sv
  - rtl/csr_counters.sv
  - rtl/csr_regs.sv
  - target: test
    files:
      - verif/csr_regs_tb.sv
